/* logic/snes_mem_pkg.sv */
// Shared types for the console memory request path
// One 16-bit word store serves loader, console CPU and softcore
// Word addresses carry 16 bits and the store ignores bits above its width
// WRAM is recognised by CPU banks 7E/7F only

`default_nettype none

package snes_mem_pkg;

    localparam int mem_aw_default = 12;                  // 4096 words

    // Upper seven address bits shared by banks 7E and 7F
    localparam logic [6:0] wram_bank_hi = 7'h3f;

    typedef logic [23:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [31:0] rv_word_t;

    // What a word operation is serving
    typedef enum logic [2:0] {
        cpu_rom  = 3'd0,
        cpu_wram = 3'd1,
        rv_lo    = 3'd2,                                 // Softcore low half, more to come
        rv_hi    = 3'd3,                                 // Softcore high half, last of two
        rv_only  = 3'd4,                                 // Softcore single half, last
        load     = 3'd5
    } op_kind_t;

    typedef struct packed {
        word_t     addr;                                 // Word address
        logic      we;
        logic [1:0] be;                                  // Byte enables, bit 1 is high byte
        word_t     wdata;
        op_kind_t  kind;
        logic      bsel;                                 // CPU byte address bit 0
        logic      word;                                 // ROM word access
    } mem_op_t;

    typedef struct packed {
        word_t     rdata;                                // Old word on writes
        op_kind_t  kind;
        logic      bsel;
        logic      word;
        logic      we;
    } mem_res_t;

    typedef struct packed {
        cpu_addr_t addr;
        logic      we;
        byte_t     wdata;
        logic      word;
    } cpu_req_t;

    // wstrb of zero is a read of both halves
    typedef struct packed {
        cpu_addr_t addr;                                 // Byte address
        rv_word_t  wdata;
        logic [3:0] wstrb;
    } rv_req_t;

endpackage

`default_nettype wire

/* logic/mem_req_decode.sv */
// Request decode and arbitration in front of the word store
// Loader and CPU never get accepted on the same edge since cpu_ready is ~loading,
// so one pending slot is enough for both and it always issues on the next edge
// Softcore halves only fill slots left free by loader and CPU traffic
// A trailing odd loader byte count leaves the last byte unwritten
// CPU writes outside WRAM are accepted and dropped

`timescale 1ns/1ps
`default_nettype none

module mem_req_decode #(
    parameter int MEM_AW = 12
) (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    loading,
    input  logic                    load_valid,
    input  snes_mem_pkg::byte_t     load_data,
    output logic                    load_ready,
    input  logic                    cpu_valid,
    input  snes_mem_pkg::cpu_req_t  cpu_req,
    output logic                    cpu_ready,
    input  logic                    rv_valid,
    input  snes_mem_pkg::rv_req_t   rv_req,
    output logic                    rv_ready,
    output logic                    op_valid,
    output snes_mem_pkg::mem_op_t   op
);

    logic                      loading_r;
    snes_mem_pkg::cpu_addr_t   load_addr;
    snes_mem_pkg::cpu_addr_t   load_addr_eff;
    snes_mem_pkg::byte_t       even_byte;
    logic                      load_acc;
    logic                      cpu_acc;
    logic                      rv_acc;
    logic                      cpu_wram_hit;
    snes_mem_pkg::mem_op_t     load_op;
    snes_mem_pkg::mem_op_t     cpu_op;
    snes_mem_pkg::mem_op_t     rv_op;
    logic                      pend_valid;
    snes_mem_pkg::mem_op_t     pend_op;
    logic                      rv_busy;
    logic                      lo_todo;
    logic                      hi_todo;
    logic                      rv_two;            // Request needs both halves
    logic                      rv_issue;
    snes_mem_pkg::rv_req_t     rv_hold;

    // ROM byte address to word, lower half of the store
    function automatic snes_mem_pkg::word_t rom_word(input snes_mem_pkg::cpu_addr_t a);
        return 16'({1'b0, a[MEM_AW-1:1]});
    endfunction

    // WRAM offset to word, upper half of the store
    function automatic snes_mem_pkg::word_t wram_word(input logic [16:0] off);
        return 16'({1'b1, off[MEM_AW-1:1]});
    endfunction

    // Softcore sees the whole store, two words per 32-bit location
    function automatic snes_mem_pkg::word_t rv_word(input snes_mem_pkg::cpu_addr_t b,
                                                    input logic half);
        return 16'({b[MEM_AW:2], half});
    endfunction

    assign load_ready = loading;
    assign cpu_ready  = ~loading;
    assign rv_ready   = ~rv_busy & ~loading & ~(cpu_valid & cpu_ready);   // CPU wins

    assign load_acc = load_valid & loading;
    assign cpu_acc  = cpu_valid & cpu_ready;
    assign rv_acc   = rv_valid & rv_ready;

    // A byte arriving with the rising edge of loading is byte zero
    assign load_addr_eff = (loading & ~loading_r) ? '0 : load_addr;

    assign cpu_wram_hit = cpu_req.addr[23:17] == snes_mem_pkg::wram_bank_hi;
    assign rv_issue     = rv_busy & ~pend_valid;

    always_comb begin
        load_op       = '0;
        load_op.addr  = rom_word(load_addr_eff);
        load_op.we    = 1'b1;
        load_op.be    = 2'b11;
        load_op.wdata = {load_data, even_byte};       // Odd byte goes high
        load_op.kind  = snes_mem_pkg::load;
        load_op.word  = 1'b1;

        cpu_op       = '0;
        cpu_op.bsel  = cpu_req.addr[0];
        cpu_op.word  = cpu_req.word;
        cpu_op.wdata = {cpu_req.wdata, cpu_req.wdata};
        if (cpu_wram_hit) begin
            cpu_op.addr = wram_word(cpu_req.addr[16:0]);
            cpu_op.we   = cpu_req.we;
            cpu_op.be   = cpu_req.addr[0] ? 2'b10 : 2'b01;
            cpu_op.kind = snes_mem_pkg::cpu_wram;
        end else begin
            cpu_op.addr = rom_word(cpu_req.addr);
            cpu_op.be   = 2'b11;
            cpu_op.kind = snes_mem_pkg::cpu_rom;
        end

        // Low half first when both are needed
        rv_op      = '0;
        rv_op.word = 1'b1;
        rv_op.we   = rv_hold.wstrb != 4'b0000;
        rv_op.addr = rv_word(rv_hold.addr, ~lo_todo);
        if (lo_todo) begin
            rv_op.wdata = rv_hold.wdata[15:0];
            rv_op.be    = rv_op.we ? rv_hold.wstrb[1:0] : 2'b11;
            rv_op.kind  = rv_two ? snes_mem_pkg::rv_lo : snes_mem_pkg::rv_only;
        end else begin
            rv_op.wdata = rv_hold.wdata[31:16];
            rv_op.be    = rv_op.we ? rv_hold.wstrb[3:2] : 2'b11;
            rv_op.kind  = rv_two ? snes_mem_pkg::rv_hi : snes_mem_pkg::rv_only;
        end
    end

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r  <= 1'b0;
            load_addr  <= '0;
            pend_valid <= 1'b0;
            op_valid   <= 1'b0;
            rv_busy    <= 1'b0;
            lo_todo    <= 1'b0;
            hi_todo    <= 1'b0;
            rv_two     <= 1'b0;
        end else begin
            loading_r <= loading;
            if (loading & ~loading_r)
                load_addr <= '0;
            if (load_acc)
                load_addr <= load_addr_eff + 24'd1;

            // Loader writes on odd bytes, CPU ROM writes go nowhere
            pend_valid <= (load_acc & load_addr_eff[0]) |
                          (cpu_acc & (~cpu_req.we | cpu_wram_hit));
            op_valid   <= pend_valid | rv_issue;

            if (rv_acc) begin
                rv_busy <= 1'b1;
                lo_todo <= (rv_req.wstrb == 4'b0000) | (|rv_req.wstrb[1:0]);
                hi_todo <= (rv_req.wstrb == 4'b0000) | (|rv_req.wstrb[3:2]);
                rv_two  <= (rv_req.wstrb == 4'b0000) |
                           ((|rv_req.wstrb[1:0]) & (|rv_req.wstrb[3:2]));
            end else if (rv_issue) begin
                if (lo_todo)
                    lo_todo <= 1'b0;
                else
                    hi_todo <= 1'b0;
                if (!(lo_todo & hi_todo))
                    rv_busy <= 1'b0;                  // Last half out
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (load_acc & ~load_addr_eff[0])
            even_byte <= load_data;
        pend_op <= load_acc ? load_op : cpu_op;
        op      <= pend_valid ? pend_op : rv_op;
        if (rv_acc)
            rv_hold <= rv_req;
    end

endmodule

`default_nettype wire

/* logic/mem_exec.sv */
// On-chip word store standing in for the shared SDRAM
// Accepts one word operation per cycle, no back-pressure
// Result appears one cycle after the operation, writes return the old word
// Address bits above MEM_AW are ignored, contents are not reset

`timescale 1ns/1ps
`default_nettype none

module mem_exec #(
    parameter int MEM_AW = 12
) (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    op_valid,
    input  snes_mem_pkg::mem_op_t   op,
    output logic                    res_valid,
    output snes_mem_pkg::mem_res_t  res
);

    localparam int mem_words = 1 << MEM_AW;

    snes_mem_pkg::word_t store [0:mem_words-1];
    logic [MEM_AW-1:0]   waddr;

    assign waddr = op.addr[MEM_AW-1:0];

    // Byte lanes written separately
    always_ff @(posedge mclk) begin
        if (op_valid && op.we) begin
            if (op.be[0])
                store[waddr][7:0] <= op.wdata[7:0];
            if (op.be[1])
                store[waddr][15:8] <= op.wdata[15:8];
        end
    end

    // Read word travels with the op's tag fields
    always_ff @(posedge mclk) begin
        if (op_valid) begin
            res.rdata <= store[waddr];                  // Read before write
            res.kind  <= op.kind;
            res.bsel  <= op.bsel;
            res.word  <= op.word;
            res.we    <= op.we;
        end
    end

    always_ff @(posedge mclk) begin
        if (!resetn)
            res_valid <= 1'b0;
        else
            res_valid <= op_valid;
    end

endmodule

`default_nettype wire

/* logic/mem_result.sv */
// Turns raw store words into client responses
// CPU ROM reads swap bytes on odd addresses unless a word read is asked for
// CPU WRAM reads return one byte, zero extended
// Softcore low word is held until the tagged last half arrives
// Load results and all write results other than the softcore's last half are dropped

`timescale 1ns/1ps
`default_nettype none

module mem_result (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    res_valid,
    input  snes_mem_pkg::mem_res_t  res,
    output logic                    cpu_rdata_valid,
    output snes_mem_pkg::word_t     cpu_rdata,
    output logic                    rv_resp_valid,
    output snes_mem_pkg::rv_word_t  rv_rdata
);

    logic                 cpu_read;
    logic                 rv_done;
    logic                 rv_lo_read;
    logic                 rv_hi_read;
    snes_mem_pkg::word_t  cpu_fmt;
    snes_mem_pkg::word_t  rv_lo_word;

    assign cpu_read = res_valid & ~res.we &
                      ((res.kind == snes_mem_pkg::cpu_rom) ||
                       (res.kind == snes_mem_pkg::cpu_wram));

    // One response per softcore request, reads or writes
    assign rv_done = res_valid &
                     ((res.kind == snes_mem_pkg::rv_hi) ||
                      (res.kind == snes_mem_pkg::rv_only));

    assign rv_lo_read = res_valid & ~res.we & (res.kind == snes_mem_pkg::rv_lo);
    assign rv_hi_read = res_valid & ~res.we & (res.kind == snes_mem_pkg::rv_hi);

    always_comb begin
        if (res.kind == snes_mem_pkg::cpu_wram)
            cpu_fmt = {8'h00, res.bsel ? res.rdata[15:8] : res.rdata[7:0]};
        else if (res.word || !res.bsel)
            cpu_fmt = res.rdata;
        else
            cpu_fmt = {res.rdata[7:0], res.rdata[15:8]};   // Odd ROM byte first
    end

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            cpu_rdata_valid <= 1'b0;
            rv_resp_valid   <= 1'b0;
        end else begin
            cpu_rdata_valid <= cpu_read;
            rv_resp_valid   <= rv_done;
        end
    end

    always_ff @(posedge mclk) begin
        if (cpu_read)
            cpu_rdata <= cpu_fmt;
        if (rv_lo_read)
            rv_lo_word <= res.rdata;
        if (rv_hi_read)
            rv_rdata <= {res.rdata, rv_lo_word};
    end

endmodule

`default_nettype wire

/* logic/snes_mem_top.sv */
// Memory request path of the console top level
// Three stages: decode, word store, result formatting
// CPU reads return in the cycle after the fourth edge counted from acceptance
// Softcore latency depends on CPU traffic, rv_resp_valid marks completion
// MEM_AW is 10 to 16, the store is on-chip and not cleared by reset

`timescale 1ns/1ps
`default_nettype none

module snes_mem_top #(
    parameter int MEM_AW = snes_mem_pkg::mem_aw_default
) (
    input  logic                    mclk,
    input  logic                    resetn,

    // ROM loader byte stream
    input  logic                    loading,
    input  logic                    load_valid,
    input  snes_mem_pkg::byte_t     load_data,
    output logic                    load_ready,

    // Console CPU port
    input  logic                    cpu_valid,
    input  snes_mem_pkg::cpu_req_t  cpu_req,
    output logic                    cpu_ready,
    output logic                    cpu_rdata_valid,
    output snes_mem_pkg::word_t     cpu_rdata,

    // Softcore port
    input  logic                    rv_valid,
    input  snes_mem_pkg::rv_req_t   rv_req,
    output logic                    rv_ready,
    output logic                    rv_resp_valid,
    output snes_mem_pkg::rv_word_t  rv_rdata
);

    logic                   op_valid;
    snes_mem_pkg::mem_op_t  op;
    logic                   res_valid;
    snes_mem_pkg::mem_res_t res;

    mem_req_decode #(.MEM_AW(MEM_AW)) decode_i (
        .mclk       (mclk),
        .resetn     (resetn),
        .loading    (loading),
        .load_valid (load_valid),
        .load_data  (load_data),
        .load_ready (load_ready),
        .cpu_valid  (cpu_valid),
        .cpu_req    (cpu_req),
        .cpu_ready  (cpu_ready),
        .rv_valid   (rv_valid),
        .rv_req     (rv_req),
        .rv_ready   (rv_ready),
        .op_valid   (op_valid),
        .op         (op)
    );

    mem_exec #(.MEM_AW(MEM_AW)) exec_i (
        .mclk       (mclk),
        .resetn     (resetn),
        .op_valid   (op_valid),
        .op         (op),
        .res_valid  (res_valid),
        .res        (res)
    );

    mem_result result_i (
        .mclk            (mclk),
        .resetn          (resetn),
        .res_valid       (res_valid),
        .res             (res),
        .cpu_rdata_valid (cpu_rdata_valid),
        .cpu_rdata       (cpu_rdata),
        .rv_resp_valid   (rv_resp_valid),
        .rv_rdata        (rv_rdata)
    );

endmodule

`default_nettype wire

/* test/tb_snes_mem.sv */
// Table-driven testbench for the console memory request path
// Expected values come from a byte-array model of the memory map
// The DUT keeps its default store width and the model follows the package default
// WRAM and softcore words are written before they are read since the store starts unknown

`timescale 1ns/1ps
`default_nettype none

module tb_snes_mem;

    localparam int store_words = 1 << snes_mem_pkg::mem_aw_default;
    localparam int half_words  = store_words / 2;
    localparam int max_steps   = 256;

    localparam logic [2:0] k_load_on   = 3'd0;
    localparam logic [2:0] k_load_byte = 3'd1;
    localparam logic [2:0] k_load_off  = 3'd2;
    localparam logic [2:0] k_cpu       = 3'd3;
    localparam logic [2:0] k_rv        = 3'd4;      // Queued without blocking the table
    localparam logic [2:0] k_idle      = 3'd5;
    localparam logic [2:0] k_wait      = 3'd6;      // Until every response is back

    typedef struct packed {
        logic [2:0]  kind;
        logic [23:0] addr;
        logic        we;
        logic        word;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_val;
    } step_t;

    logic                    mclk;
    logic                    resetn;
    logic                    loading;
    logic                    load_valid;
    snes_mem_pkg::byte_t     load_data;
    logic                    load_ready;
    logic                    cpu_valid;
    snes_mem_pkg::cpu_req_t  cpu_req;
    logic                    cpu_ready;
    logic                    cpu_rdata_valid;
    snes_mem_pkg::word_t     cpu_rdata;
    logic                    rv_valid;
    snes_mem_pkg::rv_req_t   rv_req;
    logic                    rv_ready;
    logic                    rv_resp_valid;
    snes_mem_pkg::rv_word_t  rv_rdata;

    step_t       steps [0:max_steps-1];
    int          n_steps;
    int          edge_count;
    int          cycle_limit;
    int          rand_seed;
    logic [7:0]  ref_mem [0:2*store_words-1];  // Byte 2w is the low byte of word w
    logic [31:0] cpu_exp_data [$];
    int          cpu_exp_edge [$];
    logic [31:0] rv_exp_data [$];
    logic        rv_exp_read [$];
    int          rv_todo [$];                  // Step indices waiting for the softcore port
    logic        rv_active;
    step_t       rv_cur;
    logic        rv_mon_read;
    logic [31:0] rv_mon_data;

    snes_mem_top dut_i (
        .mclk(mclk), .resetn(resetn),
        .loading(loading), .load_valid(load_valid), .load_data(load_data),
        .load_ready(load_ready),
        .cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready),
        .cpu_rdata_valid(cpu_rdata_valid), .cpu_rdata(cpu_rdata),
        .rv_valid(rv_valid), .rv_req(rv_req), .rv_ready(rv_ready),
        .rv_resp_valid(rv_resp_valid), .rv_rdata(rv_rdata)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
            stop_with_error($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                                      $time, name, got, want));
    endtask

    // ROM byte a sits in word a/2 of the lower half
    function automatic int rom_index(input logic [23:0] a);
        return 2 * ((a / 2) % half_words) + a % 2;
    endfunction

    function automatic int wram_index(input logic [23:0] a);
        int off;
        off = a % 131072;                           // 17-bit offset in banks 7E/7F
        return 2 * (half_words + (off / 2) % half_words) + off % 2;
    endfunction

    // Lanes 0 and 1 in the low word, 2 and 3 in the next one
    function automatic int rv_index(input logic [23:0] b, input int lane);
        int wrd;
        wrd = ((b / 4) * 2 + lane / 2) % store_words;
        return 2 * wrd + lane % 2;
    endfunction

    function automatic logic in_wram(input logic [23:0] a);
        return a[23:16] == 8'h7e || a[23:16] == 8'h7f;
    endfunction

    task automatic add_step(input logic [2:0] kind, input logic [23:0] addr, input logic we,
                            input logic word, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
        steps[n_steps] = {kind, addr, we, word, wdata, wstrb, 32'h0};
        n_steps++;
    endtask

    task automatic build_table();
        int i;
        n_steps = 0;
        add_step(k_load_on, 0, 0, 0, 0, 0);
        for (i = 0; i < 64; i++)
            add_step(k_load_byte, 0, 0, 0, $urandom & 32'hff, 0);
        add_step(k_load_off, 0, 0, 0, 0, 0);
        for (i = 0; i < 16; i += 2)
            add_step(k_cpu, i, 0, 0, 0, 0);            // Even reads stream back to back
        add_step(k_cpu, 24'h000011, 0, 1, 0, 0);
        add_step(k_cpu, 24'h00003f, 0, 1, 0, 0);
        add_step(k_cpu, 24'h010006, 0, 0, 0, 0);       // Wraps onto word 3
        add_step(k_cpu, 24'h000001, 0, 0, 0, 0);
        add_step(k_cpu, 24'h000005, 0, 0, 0, 0);
        add_step(k_cpu, 24'h000017, 0, 0, 0, 0);
        add_step(k_cpu, 24'h00003d, 0, 0, 0, 0);
        add_step(k_cpu, 24'h400021, 0, 0, 0, 0);
        add_step(k_cpu, 24'h000004, 1, 0, 32'ha5, 0);  // ROM stays as loaded
        add_step(k_cpu, 24'h000004, 0, 0, 0, 0);
        add_step(k_wait, 0, 0, 0, 0, 0);
        add_step(k_cpu, 24'h7e0010, 1, 0, 32'h11, 0);
        add_step(k_cpu, 24'h7e0011, 1, 0, 32'h22, 0);
        add_step(k_cpu, 24'h7e0011, 1, 0, 32'h5c, 0);
        add_step(k_cpu, 24'h7e0010, 0, 0, 0, 0);
        add_step(k_cpu, 24'h7e0011, 0, 0, 0, 0);
        add_step(k_cpu, 24'h7f0020, 1, 0, 32'h33, 0);
        add_step(k_cpu, 24'h7f0021, 1, 0, 32'h44, 0);
        add_step(k_cpu, 24'h7f0020, 1, 0, 32'hc7, 0);
        add_step(k_cpu, 24'h7f0020, 0, 0, 0, 0);
        add_step(k_cpu, 24'h7f0021, 0, 0, 0, 0);
        add_step(k_wait, 0, 0, 0, 0, 0);
        add_step(k_rv, 24'h001800, 0, 0, 32'h01234567, 4'b1111);
        add_step(k_rv, 24'h001800, 0, 0, 0, 4'b0000);
        add_step(k_rv, 24'h001800, 0, 0, 32'h89abcdef, 4'b0011);
        add_step(k_rv, 24'h001800, 0, 0, 0, 4'b0000);
        add_step(k_rv, 24'h001800, 0, 0, 32'hfedcba98, 4'b1100);
        add_step(k_rv, 24'h001800, 0, 0, 0, 4'b0000);
        add_step(k_rv, 24'h001800, 0, 0, 32'h00550000, 4'b0100);
        add_step(k_rv, 24'h003800, 0, 0, 0, 4'b0000);  // Aliases 0x1800
        add_step(k_wait, 0, 0, 0, 0, 0);
        // Softcore ROM reads squeezed between CPU reads
        add_step(k_rv, 24'h000010, 0, 0, 0, 4'b0000);
        add_step(k_cpu, 24'h000014, 0, 0, 0, 0);
        add_step(k_cpu, 24'h000016, 0, 0, 0, 0);
        add_step(k_idle, 0, 0, 0, 0, 0);
        add_step(k_cpu, 24'h000018, 0, 0, 0, 0);
        add_step(k_cpu, 24'h00001a, 0, 0, 0, 0);
        add_step(k_idle, 0, 0, 0, 0, 0);
        add_step(k_rv, 24'h00003c, 0, 0, 0, 4'b0000);
        add_step(k_cpu, 24'h00001e, 0, 0, 0, 0);
        add_step(k_cpu, 24'h000001, 0, 0, 0, 0);
        add_step(k_idle, 0, 0, 0, 0, 0);
        add_step(k_cpu, 24'h000003, 0, 0, 0, 0);
        add_step(k_wait, 0, 0, 0, 0, 0);
    endtask

    // Walks the table in order and fills in the expected read values
    task automatic compute_expected();
        step_t      s;
        int         i;
        int         lane;
        int         idx;
        int         ld_addr;
        logic [7:0] even;
        ld_addr = 0;
        even = 8'h00;
        for (i = 0; i < n_steps; i++) begin
            s = steps[i];
            case (s.kind)
                k_load_on:
                    ld_addr = 0;
                k_load_byte: begin
                    if (ld_addr % 2 == 0) begin
                        even = s.wdata[7:0];
                    end else begin
                        ref_mem[rom_index(ld_addr - 1)] = even;
                        ref_mem[rom_index(ld_addr)] = s.wdata[7:0];
                    end
                    ld_addr++;
                end
                k_cpu: begin
                    if (in_wram(s.addr)) begin
                        idx = wram_index(s.addr);
                        if (s.we)
                            ref_mem[idx] = s.wdata[7:0];
                        else
                            s.exp_val = {24'h0, ref_mem[idx]};
                    end else if (!s.we) begin
                        idx = rom_index(s.addr - s.addr % 2);
                        if (s.word || s.addr % 2 == 0)
                            s.exp_val = {16'h0, ref_mem[idx + 1], ref_mem[idx]};
                        else
                            s.exp_val = {16'h0, ref_mem[idx], ref_mem[idx + 1]};
                    end
                end
                k_rv: begin
                    for (lane = 0; lane < 4; lane++) begin
                        idx = rv_index(s.addr, lane);
                        if (s.wstrb[lane])
                            ref_mem[idx] = s.wdata[8*lane +: 8];
                        s.exp_val[8*lane +: 8] = ref_mem[idx];
                    end
                end
                default: ;
            endcase
            steps[i] = s;
        end
    endtask

    task automatic drive_step(input step_t s);
        @(negedge mclk);
        cpu_valid  = 1'b0;
        load_valid = 1'b0;
        case (s.kind)
            k_load_on: begin
                loading = 1'b1;
                #1;
                check_value("cpu_ready", cpu_ready, 0);
                check_value("load_ready", load_ready, 1);
            end
            k_load_off:
                loading = 1'b0;
            k_load_byte: begin
                load_valid = 1'b1;
                load_data  = s.wdata[7:0];
                #1;
                check_value("load_ready", load_ready, 1);
                check_value("cpu_ready", cpu_ready, 0);
                check_value("rv_ready", rv_ready, 0);
                @(posedge mclk);
            end
            k_cpu: begin
                cpu_valid     = 1'b1;
                cpu_req.addr  = s.addr;
                cpu_req.we    = s.we;
                cpu_req.wdata = s.wdata[7:0];
                cpu_req.word  = s.word;
                #1;
                while (cpu_ready !== 1'b1) begin
                    @(negedge mclk);
                    #1;
                end
                if (!s.we) begin
                    cpu_exp_data.push_back(s.exp_val);
                    cpu_exp_edge.push_back(edge_count + 4);   // Accept edge plus three
                end
                @(posedge mclk);
            end
            default: ;
        endcase
    endtask

    task automatic wait_for_drain();
        @(negedge mclk);
        cpu_valid  = 1'b0;
        load_valid = 1'b0;
        #1;
        while (rv_todo.size() != 0 || rv_active || cpu_exp_data.size() != 0 ||
               rv_exp_data.size() != 0) begin
            @(negedge mclk);
            #1;
        end
    endtask

    // Softcore requests run beside the table so they can overlap CPU traffic
    initial begin
        wait (resetn === 1'b1);
        forever begin
            @(negedge mclk);
            rv_valid = 1'b0;
            if (rv_todo.size() != 0) begin
                rv_cur       = steps[rv_todo.pop_front()];
                rv_active    = 1'b1;
                rv_valid     = 1'b1;
                rv_req.addr  = rv_cur.addr;
                rv_req.wdata = rv_cur.wdata;
                rv_req.wstrb = rv_cur.wstrb;
                #1;
                while (rv_ready !== 1'b1) begin
                    @(negedge mclk);
                    #1;
                end
                rv_exp_data.push_back(rv_cur.exp_val);
                rv_exp_read.push_back(rv_cur.wstrb == 4'b0000);
                rv_active = 1'b0;
                @(posedge mclk);
            end
        end
    end

    always @(negedge mclk) begin
        if (cpu_rdata_valid === 1'b1) begin
            if (cpu_exp_data.size() == 0) begin
                stop_with_error("CPU read data came back with no read outstanding");
            end else begin
                check_value("cpu_rdata", cpu_rdata, cpu_exp_data.pop_front());
                check_value("cpu_rdata_valid edge", edge_count, cpu_exp_edge.pop_front());
            end
        end
        if (rv_resp_valid === 1'b1) begin
            if (rv_exp_read.size() == 0) begin
                stop_with_error("softcore response came back with no request outstanding");
            end else begin
                rv_mon_read = rv_exp_read.pop_front();
                rv_mon_data = rv_exp_data.pop_front();
                if (rv_mon_read)
                    check_value("rv_rdata", rv_rdata, rv_mon_data);
            end
        end
    end

    always @(posedge mclk) begin
        edge_count = edge_count + 1;
        if (edge_count > cycle_limit)
            stop_with_error($sformatf("run timed out after %0d cycles", edge_count));
    end

    initial begin : main_seq
        step_t s;
        int    i;
        resetn     = 1'b0;
        loading    = 1'b0;
        load_valid = 1'b0;
        load_data  = '0;
        cpu_valid  = 1'b0;
        cpu_req    = '0;
        rv_valid   = 1'b0;
        rv_req     = '0;
        rv_active  = 1'b0;
        rand_seed  = 32'h26e3_304e;
        void'($urandom(rand_seed));
        build_table();
        compute_expected();
        cycle_limit = n_steps * 8 + 100;
        repeat (4) begin
            @(posedge mclk);                          // One reset edge per cycle
            @(negedge mclk);
            check_value("cpu_rdata_valid", cpu_rdata_valid, 0);
            check_value("rv_resp_valid", rv_resp_valid, 0);
        end
        resetn = 1'b1;
        #1;
        check_value("rv_ready", rv_ready, 1);
        check_value("cpu_ready", cpu_ready, 1);
        for (i = 0; i < n_steps; i++) begin
            s = steps[i];
            if (s.kind == k_rv)
                rv_todo.push_back(i);
            else if (s.kind == k_wait)
                wait_for_drain();
            else
                drive_step(s);
        end
        wait_for_drain();
        repeat (10) @(negedge mclk);                  // Stray responses show up here
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/snes_mem_pkg.sv
logic/mem_req_decode.sv
logic/mem_exec.sv
logic/mem_result.sv
logic/snes_mem_top.sv
test/tb_snes_mem.sv
